/* logic/mdu_pkg.sv */
`default_nettype none

package mdu_pkg;

    // operation code as issued to the unit
    typedef logic [2:0] mdu_op_t;

    localparam mdu_op_t OP_MULT  = 3'd0;
    localparam mdu_op_t OP_MULTU = 3'd1;
    localparam mdu_op_t OP_DIV   = 3'd2;
    localparam mdu_op_t OP_DIVU  = 3'd3;
    localparam mdu_op_t OP_MFHI  = 3'd4;
    localparam mdu_op_t OP_MFLO  = 3'd5;

    // physical register tag on writeback
    typedef logic [5:0] prf_num_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_MUL,
        S_DIV_RUN,
        S_DIV_FIX
    } mdu_state_e;

endpackage

`default_nettype wire

/* logic/mdu_seq_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface mdu_seq_if;

    logic mul_start;
    logic div_load;
    logic div_step;
    logic div_finish;
    logic op_signed;
    logic mf_sel_hi;
    logic mf_read;

    modport seq (
        output mul_start, div_load, div_step, div_finish,
        output op_signed, mf_sel_hi, mf_read
    );

    modport mul (input mul_start, op_signed);

    modport div (input div_load, div_step, div_finish, op_signed);

    modport hilo (input mf_read, mf_sel_hi);

endinterface

`default_nettype wire

/* logic/mdu_seq_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module mdu_seq_fsm #(
    parameter int XLEN = 32
) (
    input  wire                 aclk,
    input  wire                 arst_n_i,
    input  wire                 op_valid_i,
    input  mdu_pkg::mdu_op_t    op_i,
    input  wire                 iter_last_i,
    mdu_seq_if.seq              seq,
    output logic                mul_busy_o,
    output logic                div_busy_o
);

    mdu_pkg::mdu_state_e state_q;
    mdu_pkg::mdu_state_e state_d;
    logic                mul_phase_q;
    logic                accept;
    logic                is_mul;
    logic                is_div;
    logic                is_mf;

    always_comb begin
        is_mul = 1'b0;
        is_div = 1'b0;
        is_mf  = 1'b0;
        case (op_i)
            mdu_pkg::OP_MULT, mdu_pkg::OP_MULTU: is_mul = 1'b1;
            mdu_pkg::OP_DIV, mdu_pkg::OP_DIVU:   is_div = 1'b1;
            mdu_pkg::OP_MFHI, mdu_pkg::OP_MFLO:  is_mf  = 1'b1;
            default: ;
        endcase
    end

    assign accept = op_valid_i && !mul_busy_o && !div_busy_o;

    // operands are only present in the accept cycle
    assign seq.mul_start  = accept && is_mul;
    assign seq.div_load   = accept && is_div;
    assign seq.mf_read    = accept && is_mf;
    assign seq.op_signed  = (op_i == mdu_pkg::OP_MULT) || (op_i == mdu_pkg::OP_DIV);
    assign seq.mf_sel_hi  = (op_i == mdu_pkg::OP_MFHI);
    assign seq.div_step   = (state_q == mdu_pkg::S_DIV_RUN);
    assign seq.div_finish = (state_q == mdu_pkg::S_DIV_FIX);

    always_comb begin
        state_d = state_q;
        case (state_q)
            mdu_pkg::S_IDLE: begin
                if (seq.mul_start) begin
                    state_d = mdu_pkg::S_MUL;
                end else if (seq.div_load) begin
                    state_d = mdu_pkg::S_DIV_RUN;
                end
            end
            mdu_pkg::S_MUL: begin
                if (mul_phase_q) begin
                    state_d = mdu_pkg::S_IDLE;
                end
            end
            mdu_pkg::S_DIV_RUN: begin
                if (iter_last_i) begin
                    state_d = mdu_pkg::S_DIV_FIX;
                end
            end
            default: state_d = mdu_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= mdu_pkg::S_IDLE;
            mul_phase_q <= 1'b0;
            mul_busy_o  <= 1'b0;
            div_busy_o  <= 1'b0;
        end else begin
            state_q     <= state_d;
            mul_phase_q <= (state_q == mdu_pkg::S_MUL) ? !mul_phase_q : 1'b0;
            mul_busy_o  <= (state_d == mdu_pkg::S_MUL);
            // stays up one more cycle while the divider result lands
            div_busy_o  <= (state_d == mdu_pkg::S_DIV_RUN) || (state_d == mdu_pkg::S_DIV_FIX)
                           || (state_q == mdu_pkg::S_DIV_FIX);
        end
    end

    a_no_issue_while_busy: assert property (@(posedge aclk) disable iff (!arst_n_i)
        op_valid_i |-> !(mul_busy_o || div_busy_o));

    a_div_run_bounded: assert property (@(posedge aclk) disable iff (!arst_n_i)
        $rose(state_q == mdu_pkg::S_DIV_RUN) |-> ##[1:XLEN] (state_q != mdu_pkg::S_DIV_RUN));

endmodule

`default_nettype wire

/* logic/div_iter_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module div_iter_counter #(
    parameter int XLEN = 32
) (
    input  wire     aclk,
    input  wire     arst_n_i,
    input  wire     load_i,
    input  wire     step_i,
    output logic    iter_last_o
);

    localparam int CNT_W = $clog2(XLEN + 1);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= CNT_W'(XLEN);
        end else if (step_i) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // last quotient bit goes in on this step
    assign iter_last_o = step_i && (cnt_q == CNT_W'(1));

    a_no_step_at_zero: assert property (@(posedge aclk) disable iff (!arst_n_i)
        step_i |-> (cnt_q != '0));

endmodule

`default_nettype wire

/* logic/mdu_multiplier.sv */
`timescale 1ns/100ps
`default_nettype none

module mdu_multiplier #(
    parameter int XLEN = 32
) (
    input  wire             aclk,
    input  wire             arst_n_i,
    mdu_seq_if.mul          seq,
    input  wire [XLEN-1:0]  src_a_i,
    input  wire [XLEN-1:0]  src_b_i,
    output logic            mul_valid_o,
    output logic [XLEN-1:0] mul_hi_o,
    output logic [XLEN-1:0] mul_lo_o
);

    logic signed [XLEN:0]     a_ext_q;
    logic signed [XLEN:0]     b_ext_q;
    logic                     s1_valid_q;
    logic signed [2*XLEN+1:0] prod_full;
    logic [2*XLEN-1:0]        prod_q;

    // one extra bit makes MULTU a signed multiply too
    always_ff @(posedge aclk) begin
        if (seq.mul_start) begin
            a_ext_q <= {seq.op_signed && src_a_i[XLEN-1], src_a_i};
            b_ext_q <= {seq.op_signed && src_b_i[XLEN-1], src_b_i};
        end
    end

    assign prod_full = a_ext_q * b_ext_q;

    always_ff @(posedge aclk) begin
        if (s1_valid_q) begin
            prod_q <= prod_full[2*XLEN-1:0];
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid_q  <= 1'b0;
            mul_valid_o <= 1'b0;
        end else begin
            s1_valid_q  <= seq.mul_start;
            mul_valid_o <= s1_valid_q;
        end
    end

    assign mul_hi_o = prod_q[2*XLEN-1:XLEN];
    assign mul_lo_o = prod_q[XLEN-1:0];

endmodule

`default_nettype wire

/* logic/mdu_divider.sv */
`timescale 1ns/100ps
`default_nettype none

module mdu_divider #(
    parameter int XLEN = 32
) (
    input  wire             aclk,
    input  wire             arst_n_i,
    mdu_seq_if.div          seq,
    input  wire [XLEN-1:0]  src_a_i,
    input  wire [XLEN-1:0]  src_b_i,
    output logic            div_valid_o,
    output logic [XLEN-1:0] quot_o,
    output logic [XLEN-1:0] rem_o
);

    logic            a_neg;
    logic            b_neg;
    logic [XLEN-1:0] a_mag;
    logic [XLEN-1:0] b_mag;

    logic [XLEN-1:0] quot_q;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] dsor_q;
    logic            q_neg_q;
    logic            r_neg_q;

    logic [XLEN:0]   rem_shift;
    logic [XLEN:0]   diff;
    logic            fits;

    assign a_neg = seq.op_signed && src_a_i[XLEN-1];
    assign b_neg = seq.op_signed && src_b_i[XLEN-1];
    assign a_mag = a_neg ? -src_a_i : src_a_i;
    assign b_mag = b_neg ? -src_b_i : src_b_i;

    // next dividend bit shifts in from the top of the quotient register
    assign rem_shift = {rem_q, quot_q[XLEN-1]};
    assign diff      = rem_shift - {1'b0, dsor_q};
    assign fits      = !diff[XLEN];

    always_ff @(posedge aclk) begin
        if (seq.div_load) begin
            quot_q  <= a_mag;
            dsor_q  <= b_mag;
            rem_q   <= '0;
            q_neg_q <= a_neg ^ b_neg;
            r_neg_q <= a_neg;
        end else if (seq.div_step) begin
            quot_q <= {quot_q[XLEN-2:0], fits};
            rem_q  <= fits ? diff[XLEN-1:0] : rem_shift[XLEN-1:0];
        end
    end

    // quotient truncates to zero, remainder follows the dividend
    always_ff @(posedge aclk) begin
        if (seq.div_finish) begin
            quot_o <= q_neg_q ? -quot_q : quot_q;
            rem_o  <= r_neg_q ? -rem_q : rem_q;
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_valid_o <= 1'b0;
        end else begin
            div_valid_o <= seq.div_finish;
        end
    end

endmodule

`default_nettype wire

/* logic/mdu_hilo.sv */
`timescale 1ns/100ps
`default_nettype none

module mdu_hilo #(
    parameter int XLEN = 32
) (
    input  wire                 aclk,
    input  wire                 arst_n_i,
    mdu_seq_if.hilo             seq,
    input  wire                 mul_valid_i,
    input  wire [XLEN-1:0]      mul_hi_i,
    input  wire [XLEN-1:0]      mul_lo_i,
    input  wire                 div_valid_i,
    input  wire [XLEN-1:0]      quot_i,
    input  wire [XLEN-1:0]      rem_i,
    input  mdu_pkg::prf_num_t   op_rd_i,
    output logic                wb_valid_o,
    output mdu_pkg::prf_num_t   wb_rd_o,
    output logic [XLEN-1:0]     wb_data_o
);

    logic [XLEN-1:0] hi_q;
    logic [XLEN-1:0] lo_q;

    // architectural pair, so it starts at zero
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (mul_valid_i) begin
            hi_q <= mul_hi_i;
            lo_q <= mul_lo_i;
        end else if (div_valid_i) begin
            hi_q <= rem_i;
            lo_q <= quot_i;
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= seq.mf_read;
        end
    end

    always_ff @(posedge aclk) begin
        if (seq.mf_read) begin
            wb_rd_o   <= op_rd_i;
            wb_data_o <= seq.mf_sel_hi ? hi_q : lo_q;
        end
    end

    a_one_result_source: assert property (@(posedge aclk) disable iff (!arst_n_i)
        !(mul_valid_i && div_valid_i));

endmodule

`default_nettype wire

/* logic/mdu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mdu_top #(
    parameter int XLEN = 32
) (
    input  wire                 aclk,
    input  wire                 arst_n_i,
    input  wire                 op_valid_i,
    input  mdu_pkg::mdu_op_t    op_i,
    input  mdu_pkg::prf_num_t   op_rd_i,
    input  wire [XLEN-1:0]      src_a_i,
    input  wire [XLEN-1:0]      src_b_i,
    output logic                mul_busy_o,
    output logic                div_busy_o,
    output logic                wb_valid_o,
    output mdu_pkg::prf_num_t   wb_rd_o,
    output logic [XLEN-1:0]     wb_data_o
);

    logic            iter_last;
    logic            mul_valid;
    logic [XLEN-1:0] mul_hi;
    logic [XLEN-1:0] mul_lo;
    logic            div_valid;
    logic [XLEN-1:0] quot;
    logic [XLEN-1:0] rem;

    mdu_seq_if seq_if ();

    mdu_seq_fsm #(
        .XLEN (XLEN)
    ) u_seq_fsm (
        .aclk        (aclk),
        .arst_n_i    (arst_n_i),
        .op_valid_i  (op_valid_i),
        .op_i        (op_i),
        .iter_last_i (iter_last),
        .seq         (seq_if.seq),
        .mul_busy_o  (mul_busy_o),
        .div_busy_o  (div_busy_o)
    );

    div_iter_counter #(
        .XLEN (XLEN)
    ) u_iter_counter (
        .aclk        (aclk),
        .arst_n_i    (arst_n_i),
        .load_i      (seq_if.div_load),
        .step_i      (seq_if.div_step),
        .iter_last_o (iter_last)
    );

    mdu_multiplier #(
        .XLEN (XLEN)
    ) u_multiplier (
        .aclk        (aclk),
        .arst_n_i    (arst_n_i),
        .seq         (seq_if.mul),
        .src_a_i     (src_a_i),
        .src_b_i     (src_b_i),
        .mul_valid_o (mul_valid),
        .mul_hi_o    (mul_hi),
        .mul_lo_o    (mul_lo)
    );

    mdu_divider #(
        .XLEN (XLEN)
    ) u_divider (
        .aclk        (aclk),
        .arst_n_i    (arst_n_i),
        .seq         (seq_if.div),
        .src_a_i     (src_a_i),
        .src_b_i     (src_b_i),
        .div_valid_o (div_valid),
        .quot_o      (quot),
        .rem_o       (rem)
    );

    mdu_hilo #(
        .XLEN (XLEN)
    ) u_hilo (
        .aclk        (aclk),
        .arst_n_i    (arst_n_i),
        .seq         (seq_if.hilo),
        .mul_valid_i (mul_valid),
        .mul_hi_i    (mul_hi),
        .mul_lo_i    (mul_lo),
        .div_valid_i (div_valid),
        .quot_i      (quot),
        .rem_i       (rem),
        .op_rd_i     (op_rd_i),
        .wb_valid_o  (wb_valid_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o)
    );

endmodule

`default_nettype wire

/* testbench/mdu_tb_tests.svh */
`ifndef MDU_TB_TESTS_SVH
`define MDU_TB_TESTS_SVH

// result and tag show up the cycle after acceptance, for one cycle only
task automatic read_and_check(input logic sel_hi, input mdu_pkg::prf_num_t rd,
                              input logic [XLEN-1:0] exp_data);
    check_value("wb_valid_o", XLEN'(wb_valid_o), '0);
    issue_op(sel_hi ? mdu_pkg::OP_MFHI : mdu_pkg::OP_MFLO, rd, '0, '0);
    check_value("wb_valid_o", XLEN'(wb_valid_o), XLEN'(1));
    check_value("wb_rd_o", XLEN'(wb_rd_o), XLEN'(rd));
    check_value("wb_data_o", wb_data_o, exp_data);
    next_cycle();
    check_value("wb_valid_o", XLEN'(wb_valid_o), '0);
endtask

task automatic run_mul(input logic is_signed, input logic [XLEN-1:0] a,
                       input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] exp_prod;
    int                busy_cycles;
    exp_prod = expected_product(is_signed, a, b);
    issue_op(is_signed ? mdu_pkg::OP_MULT : mdu_pkg::OP_MULTU, next_tag(), a, b);
    measure_busy(1'b0, busy_cycles);
    check_value("mul_busy_o cycles", XLEN'(busy_cycles), XLEN'(2));
    read_and_check(1'b1, next_tag(), exp_prod[2*XLEN-1:XLEN]);
    read_and_check(1'b0, next_tag(), exp_prod[XLEN-1:0]);
endtask

task automatic run_div(input logic is_signed, input logic [XLEN-1:0] a,
                       input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] exp_pair;
    int                busy_cycles;
    exp_pair = expected_divide(is_signed, a, b);
    issue_op(is_signed ? mdu_pkg::OP_DIV : mdu_pkg::OP_DIVU, next_tag(), a, b);
    measure_busy(1'b1, busy_cycles);
    check_value("div_busy_o cycles", XLEN'(busy_cycles), XLEN'(XLEN + 2));
    read_and_check(1'b0, next_tag(), exp_pair[XLEN-1:0]);
    read_and_check(1'b1, next_tag(), exp_pair[2*XLEN-1:XLEN]);
endtask

task automatic test_reset_state();
    check_value("mul_busy_o", XLEN'(mul_busy_o), '0);
    check_value("div_busy_o", XLEN'(div_busy_o), '0);
    check_value("wb_valid_o", XLEN'(wb_valid_o), '0);
    read_and_check(1'b1, next_tag(), '0);
    read_and_check(1'b0, next_tag(), '0);
endtask

task automatic test_multiply();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    int              i;
    for (i = 0; i < 20; i++) begin
        a = next_operand();
        b = next_operand();
        run_mul(1'b1, a, b);
        run_mul(1'b0, a, b);
    end
    run_mul(1'b1, MOST_NEG, MOST_NEG);
    run_mul(1'b0, '1, '1);
endtask

task automatic test_divide();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    int              i;
    for (i = 0; i < 24; i++) begin
        a = next_operand();
        b = next_operand();
        // narrower divisors give longer quotients
        b = b >> a[4:0];
        run_div(1'b1, a, b);
        run_div(1'b0, a, b);
    end
    run_div(1'b1, MOST_NEG, '1);
    run_div(1'b1, MOST_NEG, XLEN'(1));
    run_div(1'b1, -XLEN'(7), XLEN'(2));
    run_div(1'b1, XLEN'(7), -XLEN'(2));
endtask

task automatic test_divide_by_zero();
    run_div(1'b1, XLEN'(1234), '0);
    run_div(1'b1, -XLEN'(1234), '0);
    run_div(1'b1, '0, '0);
    run_div(1'b1, MOST_NEG, '0);
    run_div(1'b0, MOST_NEG, '0);
    run_div(1'b0, '0, '0);
endtask

`endif

/* testbench/mdu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mdu_tb;

    localparam int XLEN = 32;
    // about 40 multiplies at 8 cycles and 60 divides at 40 cycles, plus margin
    localparam int MAX_CYCLES = 6000;
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic              aclk;
    logic              arst_n_i;
    logic              op_valid_i;
    mdu_pkg::mdu_op_t  op_i;
    mdu_pkg::prf_num_t op_rd_i;
    logic [XLEN-1:0]   src_a_i;
    logic [XLEN-1:0]   src_b_i;
    logic              mul_busy_o;
    logic              div_busy_o;
    logic              wb_valid_o;
    mdu_pkg::prf_num_t wb_rd_o;
    logic [XLEN-1:0]   wb_data_o;

    logic [31:0]       rng_state;
    mdu_pkg::prf_num_t tag_cnt;
    int                cycle_cnt = 0;

    mdu_top #(
        .XLEN (XLEN)
    ) uut (
        .aclk       (aclk),
        .arst_n_i   (arst_n_i),
        .op_valid_i (op_valid_i),
        .op_i       (op_i),
        .op_rd_i    (op_rd_i),
        .src_a_i    (src_a_i),
        .src_b_i    (src_b_i),
        .mul_busy_o (mul_busy_o),
        .div_busy_o (div_busy_o),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT did not finish the tests", cycle_cnt);
            $display("SOME TESTS FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [XLEN-1:0] next_operand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic mdu_pkg::prf_num_t next_tag();
        tag_cnt = tag_cnt + mdu_pkg::prf_num_t'(1);
        return tag_cnt;
    endfunction

    // full width product of the extended operands
    function automatic logic [2*XLEN-1:0] expected_product(input logic is_signed,
                                                           input logic [XLEN-1:0] a,
                                                           input logic [XLEN-1:0] b);
        logic signed [2*XLEN-1:0] sa;
        logic signed [2*XLEN-1:0] sb;
        sa = is_signed ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
        sb = is_signed ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        return sa * sb;
    endfunction

    // returns {remainder, quotient}
    function automatic logic [2*XLEN-1:0] expected_divide(input logic is_signed,
                                                          input logic [XLEN-1:0] a,
                                                          input logic [XLEN-1:0] b);
        logic signed [XLEN:0] sa;
        logic signed [XLEN:0] sb;
        logic signed [XLEN:0] q;
        logic signed [XLEN:0] r;
        if (b == '0) begin
            if (is_signed && a[XLEN-1]) begin
                return {a, XLEN'(1)};
            end
            return {a, {XLEN{1'b1}}};
        end
        sa = is_signed ? {a[XLEN-1], a} : {1'b0, a};
        sb = is_signed ? {b[XLEN-1], b} : {1'b0, b};
        q = sa / sb;
        r = sa % sb;
        return {r[XLEN-1:0], q[XLEN-1:0]};
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge aclk);
        #2;
    endtask

    // waits out any busy level, then holds the op for one accepting edge
    task automatic issue_op(input mdu_pkg::mdu_op_t op, input mdu_pkg::prf_num_t rd,
                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        while (mul_busy_o || div_busy_o) begin
            next_cycle();
        end
        op_valid_i = 1'b1;
        op_i       = op;
        op_rd_i    = rd;
        src_a_i    = a;
        src_b_i    = b;
        next_cycle();
        op_valid_i = 1'b0;
    endtask

    task automatic measure_busy(input logic for_div, output int cycles);
        cycles = 0;
        while (for_div ? div_busy_o : mul_busy_o) begin
            cycles = cycles + 1;
            next_cycle();
        end
    endtask

    `include "mdu_tb_tests.svh"

    initial begin
        arst_n_i   = 1'b0;
        op_valid_i = 1'b0;
        op_i       = mdu_pkg::OP_MULT;
        op_rd_i    = '0;
        src_a_i    = '0;
        src_b_i    = '0;
        rng_state  = 32'd54;
        tag_cnt    = '0;
        repeat (3) @(posedge aclk);
        #2;
        arst_n_i = 1'b1;
        test_reset_state();
        test_multiply();
        test_divide();
        test_divide_by_zero();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+testbench
logic/mdu_pkg.sv
logic/mdu_seq_if.sv
logic/mdu_seq_fsm.sv
logic/div_iter_counter.sv
logic/mdu_multiplier.sv
logic/mdu_divider.sv
logic/mdu_hilo.sv
logic/mdu_top.sv
testbench/mdu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the MDU testbench with Verilator
rm -rf obj_dir
verilator --binary --timing --assert --top-module mdu_tb -f filelist.f > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vmdu_tb > sim.log 2>&1
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "no pass result in sim.log"; exit 1; }
echo "simulation passed"
